/* logic/uart_rgb_pkg.sv */
package uart_rgb_pkg;

    // one serial data byte
    typedef logic [7:0] byte_t;

    // colour brightness, 0 to 3
    typedef logic [1:0] level_t;

    // pwm phase, one period is 8 clocks
    typedef logic [2:0] pwm_count_t;

    // oversampling ticks within one bit
    typedef logic [3:0] tick_count_t;

    // data bit position, lsb first
    typedef logic [2:0] bit_index_t;

    localparam int oversample = 16;

    // accepted line terminators
    localparam byte_t ascii_cr = 8'd13;
    localparam byte_t ascii_lf = 8'd10;

    localparam int min_command_bytes = 6;

    typedef enum logic [1:0] {
        print_ready,
        await_command,
        apply_levels,
        print_control
    } console_state_t;

endpackage

/* logic/command_if.sv */
`timescale 1ns/1ps

interface command_if;

    // buffer side, levels valid with line_ready
    logic line_ready;
    uart_rgb_pkg::level_t red_level;
    uart_rgb_pkg::level_t green_level;
    uart_rgb_pkg::level_t blue_level;

    // control side, empties the history
    logic clear;

    modport buffer (output line_ready, red_level, green_level, blue_level, input clear);

    modport control (input line_ready, output clear);

endinterface

/* logic/baud_tick_gen.sv */
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter int baud_divisor = 27
) (
    input  logic clock,
    input  logic reset,
    output logic tick
);

    localparam int count_width = (baud_divisor > 1) ? $clog2(baud_divisor) : 1;

    logic [count_width-1:0] count;

    // wrap marks one tick per divisor period
    assign tick = (count == count_width'(baud_divisor - 1));

    always_ff @(posedge clock) begin
        if (reset || tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

/* logic/uart_receiver.sv */
`timescale 1ns/1ps

module uart_receiver (
    input  logic                clock,
    input  logic                reset,
    input  logic                tick,
    input  logic                rx,
    output uart_rgb_pkg::byte_t rx_byte,
    output logic                rx_valid
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start_bit,
        rx_data_bits,
        rx_stop_bit
    } rx_state_t;

    localparam uart_rgb_pkg::tick_count_t half_tick =
        uart_rgb_pkg::tick_count_t'(uart_rgb_pkg::oversample / 2 - 1);
    localparam uart_rgb_pkg::tick_count_t last_tick =
        uart_rgb_pkg::tick_count_t'(uart_rgb_pkg::oversample - 1);

    rx_state_t state;
    uart_rgb_pkg::tick_count_t tick_count;
    uart_rgb_pkg::bit_index_t bit_index;
    uart_rgb_pkg::byte_t shift_q;
    logic sample;

    // mid-bit sample point once the start bit is confirmed
    assign sample = tick && (tick_count == last_tick);

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= rx_idle;
            tick_count <= '0;
            bit_index  <= '0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    if (!rx) begin
                        state      <= rx_start_bit;
                        tick_count <= '0;
                    end
                end
                rx_start_bit: begin
                    if (tick && tick_count == half_tick) begin
                        tick_count <= '0;
                        bit_index  <= '0;
                        // a glitch shorter than half a bit is dropped
                        state      <= rx ? rx_idle : rx_data_bits;
                    end else if (tick) begin
                        tick_count <= tick_count + 1'b1;
                    end
                end
                rx_data_bits: begin
                    if (tick) begin
                        tick_count <= tick_count + 1'b1;
                    end
                    if (sample) begin
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == uart_rgb_pkg::bit_index_t'(7)) begin
                            state <= rx_stop_bit;
                        end
                    end
                end
                rx_stop_bit: begin
                    if (tick) begin
                        tick_count <= tick_count + 1'b1;
                    end
                    if (sample) begin
                        rx_valid <= 1'b1;
                        state    <= rx_idle;
                    end
                end
            endcase
        end
    end

    // lsb first, output held until the next stop bit
    always_ff @(posedge clock) begin
        if (state == rx_data_bits && sample) begin
            shift_q <= {rx, shift_q[7:1]};
        end
        if (state == rx_stop_bit && sample) begin
            rx_byte <= shift_q;
        end
    end

endmodule

/* logic/uart_transmitter.sv */
`timescale 1ns/1ps

module uart_transmitter (
    input  logic                clock,
    input  logic                reset,
    input  logic                tick,
    input  uart_rgb_pkg::byte_t tx_byte,
    input  logic                tx_start,
    output logic                tx_done,
    output logic                tx
);

    typedef enum logic [1:0] {
        tx_idle,
        tx_start_bit,
        tx_data_bits,
        tx_stop_bit
    } tx_state_t;

    localparam uart_rgb_pkg::tick_count_t last_tick =
        uart_rgb_pkg::tick_count_t'(uart_rgb_pkg::oversample - 1);

    tx_state_t state;
    uart_rgb_pkg::tick_count_t tick_count;
    uart_rgb_pkg::bit_index_t bit_index;
    uart_rgb_pkg::byte_t data_q;
    logic pending;
    logic busy;
    logic bit_end;

    // pending covers the wait for the first tick
    assign busy    = (state != tx_idle) || pending;
    assign bit_end = tick && (tick_count == last_tick);
    assign tx_done = (state == tx_stop_bit) && bit_end;

    always_ff @(posedge clock) begin
        if (tx_start && !busy) begin
            data_q <= tx_byte;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= tx_idle;
            pending    <= 1'b0;
            tick_count <= '0;
            bit_index  <= '0;
        end else if (state == tx_idle) begin
            if (pending && tick) begin
                pending    <= 1'b0;
                state      <= tx_start_bit;
                tick_count <= '0;
            end else if (tx_start && !busy) begin
                pending <= 1'b1;
            end
        end else begin
            if (tick) begin
                tick_count <= bit_end ? '0 : tick_count + 1'b1;
            end
            if (bit_end) begin
                case (state)
                    tx_start_bit: begin
                        state     <= tx_data_bits;
                        bit_index <= '0;
                    end
                    tx_data_bits: begin
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == uart_rgb_pkg::bit_index_t'(7)) begin
                            state <= tx_stop_bit;
                        end
                    end
                    default: state <= tx_idle;
                endcase
            end
        end
    end

    // line level from state and bit position
    always_comb begin
        case (state)
            tx_start_bit: tx = 1'b0;
            tx_data_bits: tx = data_q[bit_index];
            default:      tx = 1'b1;
        endcase
    end

endmodule

/* logic/command_buffer.sv */
`timescale 1ns/1ps

module command_buffer (
    input  logic                clock,
    input  logic                reset,
    input  uart_rgb_pkg::byte_t rx_byte,
    input  logic                rx_valid,
    command_if.buffer           cmd
);

    uart_rgb_pkg::byte_t history [0:5];
    logic [2:0] byte_count;
    logic is_terminator;
    logic line_full;

    // ascii '0' to '3' give their value, anything else is off
    function automatic uart_rgb_pkg::level_t digit_level(input uart_rgb_pkg::byte_t ch);
        if (ch >= "0" && ch <= "3") begin
            return uart_rgb_pkg::level_t'(ch - "0");
        end
        return '0;
    endfunction

    assign is_terminator = (rx_byte == uart_rgb_pkg::ascii_cr) ||
                           (rx_byte == uart_rgb_pkg::ascii_lf);
    assign line_full     = (byte_count == 3'(uart_rgb_pkg::min_command_bytes));

    // newest byte in history[0], terminators are not stored
    always_ff @(posedge clock) begin
        if (cmd.clear) begin
            for (int i = 0; i < 6; i++) begin
                history[i] <= '0;
            end
        end else if (rx_valid && !is_terminator) begin
            for (int i = 5; i > 0; i--) begin
                history[i] <= history[i-1];
            end
            history[0] <= rx_byte;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            byte_count     <= '0;
            cmd.line_ready <= 1'b0;
        end else begin
            cmd.line_ready <= 1'b0;
            if (cmd.clear) begin
                byte_count <= '0;
            end else if (rx_valid && is_terminator) begin
                // short lines just restart the count
                byte_count     <= '0;
                cmd.line_ready <= line_full;
            end else if (rx_valid && !line_full) begin
                byte_count <= byte_count + 1'b1;
            end
        end
    end

    // fifth, third and first byte before the terminator
    always_ff @(posedge clock) begin
        if (rx_valid && is_terminator && line_full) begin
            cmd.red_level   <= digit_level(history[4]);
            cmd.green_level <= digit_level(history[2]);
            cmd.blue_level  <= digit_level(history[0]);
        end
    end

endmodule

/* logic/pwm_driver.sv */
`timescale 1ns/1ps

module pwm_driver (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 load,
    input  uart_rgb_pkg::level_t red_level,
    input  uart_rgb_pkg::level_t green_level,
    input  uart_rgb_pkg::level_t blue_level,
    output logic                 pwm_red,
    output logic                 pwm_green,
    output logic                 pwm_blue
);

    uart_rgb_pkg::level_t red_q;
    uart_rgb_pkg::level_t green_q;
    uart_rgb_pkg::level_t blue_q;
    uart_rgb_pkg::pwm_count_t pwm_count;

    always_ff @(posedge clock) begin
        if (reset) begin
            red_q     <= '0;
            green_q   <= '0;
            blue_q    <= '0;
            pwm_count <= '0;
        end else begin
            pwm_count <= pwm_count + 1'b1;
            if (load) begin
                red_q   <= red_level;
                green_q <= green_level;
                blue_q  <= blue_level;
            end
        end
    end

    // duty is level/8
    assign pwm_red   = (pwm_count < uart_rgb_pkg::pwm_count_t'(red_q));
    assign pwm_green = (pwm_count < uart_rgb_pkg::pwm_count_t'(green_q));
    assign pwm_blue  = (pwm_count < uart_rgb_pkg::pwm_count_t'(blue_q));

endmodule

/* logic/console_control.sv */
`timescale 1ns/1ps

module console_control (
    input  logic                clock,
    input  logic                reset,
    command_if.control          cmd,
    output uart_rgb_pkg::byte_t tx_byte,
    output logic                tx_start,
    input  logic                tx_done,
    output logic                load
);

    // message rom layout
    localparam logic [3:0] ready_last    = 4'd6;
    localparam logic [3:0] control_first = 4'd7;
    localparam logic [3:0] control_last  = 4'd15;

    uart_rgb_pkg::console_state_t state;
    logic [3:0] msg_index;
    logic sending;

    // "Ready" LF CR, then "Control" LF CR
    function automatic uart_rgb_pkg::byte_t message_rom(input logic [3:0] index);
        case (index)
            4'd0:  return "R";
            4'd1:  return "e";
            4'd2:  return "a";
            4'd3:  return "d";
            4'd4:  return "y";
            4'd5:  return uart_rgb_pkg::ascii_lf;
            4'd6:  return uart_rgb_pkg::ascii_cr;
            4'd7:  return "C";
            4'd8:  return "o";
            4'd9:  return "n";
            4'd10: return "t";
            4'd11: return "r";
            4'd12: return "o";
            4'd13: return "l";
            4'd14: return uart_rgb_pkg::ascii_lf;
            default: return uart_rgb_pkg::ascii_cr;
        endcase
    endfunction

    assign tx_byte = message_rom(msg_index);

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= uart_rgb_pkg::print_ready;
            msg_index <= '0;
            sending   <= 1'b0;
            tx_start  <= 1'b0;
            load      <= 1'b0;
            cmd.clear <= 1'b0;
        end else begin
            tx_start  <= 1'b0;
            load      <= 1'b0;
            cmd.clear <= 1'b0;
            case (state)
                uart_rgb_pkg::print_ready, uart_rgb_pkg::print_control: begin
                    if (!sending) begin
                        tx_start <= 1'b1;
                        sending  <= 1'b1;
                    end else if (tx_done) begin
                        sending <= 1'b0;
                        if (state == uart_rgb_pkg::print_ready && msg_index == ready_last) begin
                            // drop whatever arrived while printing
                            cmd.clear <= 1'b1;
                            msg_index <= control_first;
                            state     <= uart_rgb_pkg::await_command;
                        end else if (msg_index == control_last) begin
                            msg_index <= '0;
                            state     <= uart_rgb_pkg::print_ready;
                        end else begin
                            msg_index <= msg_index + 1'b1;
                        end
                    end
                end
                uart_rgb_pkg::await_command: begin
                    if (cmd.line_ready) begin
                        load  <= 1'b1;
                        state <= uart_rgb_pkg::apply_levels;
                    end
                end
                uart_rgb_pkg::apply_levels: begin
                    // first "Control" byte goes out right after load
                    tx_start <= 1'b1;
                    sending  <= 1'b1;
                    state    <= uart_rgb_pkg::print_control;
                end
            endcase
        end
    end

endmodule

/* logic/uart_rgb_top.sv */
`timescale 1ns/1ps

module uart_rgb_top #(
    parameter int baud_divisor = 27
) (
    input  logic clock,
    input  logic reset,
    input  logic uart_rx,
    output logic uart_tx,
    output logic pwm_red,
    output logic pwm_green,
    output logic pwm_blue
);

    logic tick;
    uart_rgb_pkg::byte_t rx_byte;
    logic rx_valid;
    uart_rgb_pkg::byte_t tx_byte;
    logic tx_start;
    logic tx_done;
    logic load;

    command_if cmd ();

    // one oversampling tick shared by both directions
    baud_tick_gen #(
        .baud_divisor (baud_divisor)
    ) i_baud_tick_gen (
        .clock (clock),
        .reset (reset),
        .tick  (tick)
    );

    uart_receiver i_receiver (
        .clock    (clock),
        .reset    (reset),
        .tick     (tick),
        .rx       (uart_rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    uart_transmitter i_transmitter (
        .clock    (clock),
        .reset    (reset),
        .tick     (tick),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_done  (tx_done),
        .tx       (uart_tx)
    );

    command_buffer i_buffer (
        .clock    (clock),
        .reset    (reset),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .cmd      (cmd.buffer)
    );

    console_control i_control (
        .clock    (clock),
        .reset    (reset),
        .cmd      (cmd.control),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_done  (tx_done),
        .load     (load)
    );

    pwm_driver i_pwm (
        .clock       (clock),
        .reset       (reset),
        .load        (load),
        .red_level   (cmd.red_level),
        .green_level (cmd.green_level),
        .blue_level  (cmd.blue_level),
        .pwm_red     (pwm_red),
        .pwm_green   (pwm_green),
        .pwm_blue    (pwm_blue)
    );

endmodule

/* verification/uart_rgb_sva.sv */
`timescale 1ns/1ps

module uart_rgb_sva (
    input logic                         clock,
    input logic                         reset,
    input logic                         rx_valid,
    input logic                         line_ready,
    input logic                         load,
    input logic                         tx_start,
    input logic                         tx_busy,
    input uart_rgb_pkg::console_state_t state
);

    int unsigned failures = 0;

    // strobes last exactly one clock
    rx_valid_pulse: assert property (@(posedge clock) disable iff (reset) rx_valid |=> !rx_valid)
        else begin
            $error("rx_valid held for more than one cycle");
            failures++;
        end

    line_ready_pulse: assert property (@(posedge clock) disable iff (reset)
        line_ready |=> !line_ready)
        else begin
            $error("line_ready held for more than one cycle");
            failures++;
        end

    load_pulse: assert property (@(posedge clock) disable iff (reset) load |=> !load)
        else begin
            $error("load held for more than one cycle");
            failures++;
        end

    // transmitter has no queue
    start_when_idle: assert property (@(posedge clock) disable iff (reset) tx_start |-> !tx_busy)
        else begin
            $error("tx_start raised while the transmitter is busy");
            failures++;
        end

    load_in_apply: assert property (@(posedge clock) disable iff (reset)
        load |-> state == uart_rgb_pkg::apply_levels)
        else begin
            $error("load raised outside apply_levels");
            failures++;
        end

endmodule

bind uart_rgb_top uart_rgb_sva i_sva (
    .clock      (clock),
    .reset      (reset),
    .rx_valid   (rx_valid),
    .line_ready (cmd.line_ready),
    .load       (load),
    .tx_start   (tx_start),
    .tx_busy    (i_transmitter.busy),
    .state      (i_control.state)
);

/* verification/uart_rgb_tb.sv */
`timescale 1ns/1ps

module uart_rgb_tb;

    localparam int baud_divisor = 4;
    localparam int clocks_per_bit = baud_divisor * uart_rgb_pkg::oversample;
    localparam int clocks_per_frame = clocks_per_bit * 10;
    localparam int max_lines = 16;

    logic clock = 1'b0;
    logic reset;
    logic uart_rx;
    logic uart_tx;
    logic pwm_red;
    logic pwm_green;
    logic pwm_blue;

    // bytes seen on uart_tx in arrival order
    uart_rgb_pkg::byte_t decoded [$];

    // prefix in slots 0 to 2 and terminator in slot 9
    uart_rgb_pkg::byte_t line_bytes [0:max_lines-1][0:9];
    uart_rgb_pkg::level_t expected_levels [0:max_lines-1][0:2];
    int line_count = 0;
    int error_count = 0;
    int cycle_count = 0;
    int timeout_limit = 0;

    uart_rgb_top #(
        .baud_divisor (baud_divisor)
    ) i_dut (
        .clock     (clock),
        .reset     (reset),
        .uart_rx   (uart_rx),
        .uart_tx   (uart_tx),
        .pwm_red   (pwm_red),
        .pwm_green (pwm_green),
        .pwm_blue  (pwm_blue)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // samples uart_tx in the middle of each bit
    always begin : serial_decoder
        uart_rgb_pkg::byte_t data;
        @(posedge clock);
        if (!reset && uart_tx === 1'b0) begin
            repeat (clocks_per_bit / 2 - 1) @(posedge clock);
            if (uart_tx !== 1'b0) begin
                $display("uart_tx start bit did not stay low until mid-bit");
                error_count++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (clocks_per_bit) @(posedge clock);
                data[i] = uart_tx;
            end
            repeat (clocks_per_bit) @(posedge clock);
            if (uart_tx !== 1'b1) begin
                $display("uart_tx stop bit missing after byte 8'h%02h", data);
                error_count++;
            end
            decoded.push_back(data);
        end
    end

    task automatic load_trace();
        int fd;
        int fields;
        int v [0:12];
        string line;
        fd = $fopen("verification/command_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the command trace file");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %d %d %d",
                                 v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                                 v[7], v[8], v[9], v[10], v[11], v[12]);
                if (fields == 13 && line_count < max_lines) begin
                    for (int i = 0; i < 10; i++) begin
                        line_bytes[line_count][i] = uart_rgb_pkg::byte_t'(v[i]);
                    end
                    for (int c = 0; c < 3; c++) begin
                        expected_levels[line_count][c] = uart_rgb_pkg::level_t'(v[10 + c]);
                    end
                    line_count++;
                end else if (fields > 0) begin
                    $display("Trace line could not be read: %s", line);
                    error_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    // 8N1 frame sent lsb first
    task automatic send_byte(input uart_rgb_pkg::byte_t value);
        uart_rx <= 1'b0;
        repeat (clocks_per_bit) @(posedge clock);
        for (int i = 0; i < 8; i++) begin
            uart_rx <= value[i];
            repeat (clocks_per_bit) @(posedge clock);
        end
        uart_rx <= 1'b1;
        repeat (clocks_per_bit) @(posedge clock);
    endtask

    task automatic next_byte(output uart_rgb_pkg::byte_t value);
        while (decoded.size() == 0) begin
            @(posedge clock);
        end
        value = decoded.pop_front();
    endtask

    task automatic check_byte(input string name, input uart_rgb_pkg::byte_t expected,
                              input uart_rgb_pkg::byte_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 8'h%02h, actual 8'h%02h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_level(input string name, input uart_rgb_pkg::level_t expected,
                               input uart_rgb_pkg::level_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic expect_message(input string name, input string text);
        uart_rgb_pkg::byte_t actual;
        for (int i = 0; i < text.len(); i++) begin
            next_byte(actual);
            check_byte($sformatf("%s byte %0d", name, i), uart_rgb_pkg::byte_t'(text[i]), actual);
        end
    endtask

    // high cycles in one 8-clock period give the level
    task automatic check_duties(input string name, input uart_rgb_pkg::level_t red,
                                input uart_rgb_pkg::level_t green,
                                input uart_rgb_pkg::level_t blue);
        int high [0:2];
        uart_rgb_pkg::level_t expected [0:2];
        expected[0] = red;
        expected[1] = green;
        expected[2] = blue;
        high = '{0, 0, 0};
        repeat (8) begin
            @(posedge clock);
            if (pwm_red) high[0]++;
            if (pwm_green) high[1]++;
            if (pwm_blue) high[2]++;
        end
        for (int c = 0; c < 3; c++) begin
            if (high[c] > 3) begin
                $display("Mismatch %s channel %0d: expected %0d, actual %0d",
                         name, c, expected[c], high[c]);
                error_count++;
            end else begin
                check_level($sformatf("%s channel %0d", name, c), expected[c],
                            uart_rgb_pkg::level_t'(high[c]));
            end
        end
    endtask

    initial begin : stimulus
        string name;
        reset = 1'b1;
        uart_rx = 1'b1;
        load_trace();
        if (line_count == 0) begin
            $display("No commands found in the trace file");
            error_count++;
        end
        timeout_limit = (line_count * 30 + 20) * clocks_per_frame;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        expect_message("reset Ready", "Ready\n\r");
        check_duties("reset pwm", 2'd0, 2'd0, 2'd0);

        for (int n = 0; n < line_count; n++) begin
            name = $sformatf("trace line %0d", n + 1);
            @(posedge clock);
            for (int i = 0; i < 10; i++) begin
                // empty prefix slots stay off the line
                if (i >= 3 || line_bytes[n][i] != 8'h00) begin
                    send_byte(line_bytes[n][i]);
                end
            end
            expect_message({name, " Control"}, "Control\n\r");
            check_duties({name, " pwm"}, expected_levels[n][0], expected_levels[n][1],
                         expected_levels[n][2]);
            expect_message({name, " Ready"}, "Ready\n\r");
        end

        repeat (2 * clocks_per_frame) @(posedge clock);
        if (decoded.size() != 0) begin
            $display("%0d unexpected bytes came out of uart_tx", decoded.size());
            error_count++;
        end
        error_count += int'(i_dut.i_sva.failures);
        $display("Errors: %0d, trace lines run: %0d", error_count, line_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
logic/uart_rgb_pkg.sv
logic/command_if.sv
logic/baud_tick_gen.sv
logic/uart_receiver.sv
logic/uart_transmitter.sv
logic/command_buffer.sv
logic/pwm_driver.sv
logic/console_control.sv
logic/uart_rgb_top.sv
verification/uart_rgb_sva.sv
verification/uart_rgb_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f project.f --top-module uart_rgb_tb -o uart_rgb_sim
	./obj_dir/uart_rgb_sim | tee $(LOG)
	grep -qx "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert -f project.f --top-module uart_rgb_tb

clean:
	rm -rf obj_dir $(LOG)

/* verification/command_trace.txt */
# pre0 pre1 pre2 cmd0 cmd1 cmd2 cmd3 cmd4 cmd5 term red green blue
# bytes in hex, prefix bytes of 00 are not sent, levels in decimal
00 00 00 52 31 47 32 42 33 0d 1 2 3
00 00 00 52 33 47 30 42 31 0a 3 0 1
00 00 00 52 39 47 41 42 2f 0d 0 0 0
00 00 00 72 33 67 33 62 30 0a 3 3 0
32 31 0d 52 30 47 33 42 32 0d 0 3 2
00 31 0a 78 32 79 31 7a 33 0d 2 1 3
